// File: build.f
+incdir+src
src/cpu_pkg.sv
src/stage_reg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/regfile.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_top.sv
test/cpu_assertions.sv
test/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module cpu_tb -Mdir "$obj_dir" -o cpu_sim -f build.f; then
    echo "verilator build failed"
    exit 1
fi

"./$obj_dir/cpu_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** TEST PASSED ***' "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// File: test/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_tb import cpu_pkg::*; ();
    localparam int    PROG_WORDS     = 256;
    localparam int    LOOP_INDEX     = PROG_WORDS - 8;  // start of the b 0 tail
    localparam int    RESET_CYCLES   = 16;
    localparam int    TIMEOUT_CYCLES = RESET_CYCLES + 3 * PROG_WORDS + 64;
    localparam int    DRAIN_CYCLES   = 8;  // window for writes past the last expected one
    localparam int    SEED           = 99;
    localparam word_t SELF_LOOP      = 32'h5000_0000;  // b 0

    typedef enum int {
        K_ADD, K_SUB, K_SLT, K_SLTU, K_AND, K_OR, K_NOR, K_XOR,
        K_SLLI, K_SRLI, K_SRAI, K_ADDI, K_LU12I, K_LD, K_BEQ, K_BNE, K_B
    } kind_e;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        word_t     data;
    } trace_rec_t;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    logic       inst_sram_en;
    word_t      inst_sram_addr;
    word_t      inst_sram_rdata = '0;
    logic       data_sram_en;
    word_t      data_sram_addr;
    word_t      data_sram_rdata = '0;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    kind_e       prog_kind [PROG_WORDS];
    reg_addr_t   prog_rd   [PROG_WORDS];
    reg_addr_t   prog_rj   [PROG_WORDS];
    reg_addr_t   prog_rk   [PROG_WORDS];  // rd field for beq and bne
    logic [19:0] prog_imm  [PROG_WORDS];
    int          prog_offs [PROG_WORDS];  // branch distance in words
    word_t       prog_mem  [PROG_WORDS];
    trace_rec_t  exp_q [$];
    word_t       load_q [$];  // expected data read addresses in program order
    word_t       final_pc;
    int          exp_next = 0;
    int          load_next = 0;
    int          cycles = 0;
    int          checked = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    logic        first_req_seen = 1'b0;
    logic        loop_reached = 1'b0;

    cpu_top cpu_top_inst (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_addr    (data_sram_addr),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #50 clk = ~clk;

    function automatic word_t sign_ext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic word_t pc_of(input int index);
        return `CPU_RESET_PC + word_t'(4 * index);
    endfunction

    // data memory content is a pure function of the byte address
    function automatic word_t load_value(input word_t addr);
        return ~{addr[31:2], 2'b00};
    endfunction

    function automatic word_t fetch_word(input word_t addr);
        word_t index;
        index = (addr - `CPU_RESET_PC) >> 2;
        if (addr < `CPU_RESET_PC || index >= PROG_WORDS) begin
            return SELF_LOOP;  // anything past the end spins
        end
        return prog_mem[index[7:0]];
    endfunction

    function automatic word_t encode_inst(input int i);
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [19:0] imm;
        logic [15:0] offs;
        rd   = prog_rd[i];
        rj   = prog_rj[i];
        rk   = prog_rk[i];
        imm  = prog_imm[i];
        offs = 16'(prog_offs[i]);
        case (prog_kind[i])
            K_ADD:   return {17'h00020, rk, rj, rd};
            K_SUB:   return {17'h00022, rk, rj, rd};
            K_SLT:   return {17'h00024, rk, rj, rd};
            K_SLTU:  return {17'h00025, rk, rj, rd};
            K_NOR:   return {17'h00028, rk, rj, rd};
            K_AND:   return {17'h00029, rk, rj, rd};
            K_OR:    return {17'h0002a, rk, rj, rd};
            K_XOR:   return {17'h0002b, rk, rj, rd};
            K_SLLI:  return {17'h00081, imm[4:0], rj, rd};
            K_SRLI:  return {17'h00089, imm[4:0], rj, rd};
            K_SRAI:  return {17'h00091, imm[4:0], rj, rd};
            K_ADDI:  return {10'h00a, imm[11:0], rj, rd};
            K_LU12I: return {7'b0001010, imm, rd};
            K_LD:    return {10'h0a2, imm[11:0], rj, rd};
            K_BEQ:   return {6'h16, offs, rj, rk};
            K_BNE:   return {6'h17, offs, rj, rk};
            default: return {6'h14, offs, 10'b0};  // b with upper offset bits zero
        endcase
    endfunction

    task automatic generate_program;
        int sel;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog_rd[i]   = reg_addr_t'(1 + $urandom % 7);
            prog_rj[i]   = reg_addr_t'($urandom % 8);
            prog_rk[i]   = reg_addr_t'($urandom % 8);
            prog_imm[i]  = 20'($urandom);
            prog_offs[i] = 1 + int'($urandom % 4);
            if (i >= LOOP_INDEX) begin
                prog_kind[i] = K_B;
                prog_offs[i] = 0;
            end else if (i < 7) begin
                prog_kind[i] = K_LU12I;  // prologue sets r1..r7
                prog_rd[i]   = reg_addr_t'(i + 1);
            end else if (i < 14) begin
                prog_kind[i] = K_ADDI;
                prog_rd[i]   = reg_addr_t'(i - 6);
                prog_rj[i]   = reg_addr_t'(i - 6);
            end else begin
                sel = int'($urandom % 20);
                prog_kind[i] = (sel > 16) ? K_LD : kind_e'(sel);  // extra loads
                if (i + prog_offs[i] > LOOP_INDEX) begin
                    prog_offs[i] = LOOP_INDEX - i;
                end
            end
            prog_mem[i] = encode_inst(i);
        end
    endtask

    // ISA interpreter that queues every register write in program order
    task automatic run_reference;
        word_t regs [32];
        word_t a;
        word_t b;
        word_t val;
        word_t ea;
        int    idx;
        int    next;
        logic  writes;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        idx = 0;
        while (idx < LOOP_INDEX) begin
            a      = regs[prog_rj[idx]];
            b      = regs[prog_rk[idx]];
            val    = '0;
            writes = 1'b1;
            next   = idx + 1;
            case (prog_kind[idx])
                K_ADD:   val = a + b;
                K_SUB:   val = a - b;
                K_SLT:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_SLTU:  val = (a < b) ? 32'd1 : 32'd0;
                K_AND:   val = a & b;
                K_OR:    val = a | b;
                K_NOR:   val = ~(a | b);
                K_XOR:   val = a ^ b;
                K_SLLI:  val = a << prog_imm[idx][4:0];
                K_SRLI:  val = a >> prog_imm[idx][4:0];
                K_SRAI:  val = $signed(a) >>> prog_imm[idx][4:0];
                K_ADDI:  val = a + sign_ext12(prog_imm[idx][11:0]);
                K_LU12I: val = {prog_imm[idx], 12'b0};
                K_LD: begin
                    ea  = a + sign_ext12(prog_imm[idx][11:0]);
                    val = load_value(ea);
                    load_q.push_back(ea);
                end
                default: begin
                    writes = 1'b0;  // branches write nothing
                    if (prog_kind[idx] == K_B
                        || (prog_kind[idx] == K_BEQ && a == b)
                        || (prog_kind[idx] == K_BNE && a != b)) begin
                        next = idx + prog_offs[idx];
                    end
                end
            endcase
            if (writes) begin
                exp_q.push_back(trace_rec_t'{pc: pc_of(idx), rd: prog_rd[idx], data: val});
                if (prog_rd[idx] != '0) begin
                    regs[prog_rd[idx]] = val;
                end
            end
            idx = next;
        end
        final_pc = pc_of(idx);
    endtask

    task automatic compare_field(input string name, input word_t expected, input word_t actual);
        assert (actual == expected) else begin
            $display("ERROR %0t: %s expected %h got %h", $time, name, expected, actual);
            value_errors = value_errors + 1;
        end
    endtask

    task automatic report_counts;
        $display("summary: %0d of %0d trace writes checked, %0d value errors, %0d other errors",
                 checked, exp_q.size(), value_errors, other_errors);
    endtask

    // synchronous instruction SRAM holding its output while en is low
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= fetch_word(inst_sram_addr);
        end
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            data_sram_rdata <= load_value(data_sram_addr);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d trace writes never appeared",
                     cycles, exp_q.size() - exp_next);
            report_counts();
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // trace and data read monitor sampling mid-cycle
    always @(negedge clk) begin
        trace_rec_t rec;
        if (reset) begin
            if (cycles >= 2) begin
                compare_field("debug_wb_rf_we", '0, word_t'(debug_wb_rf_we));
                compare_field("data_sram_en", '0, word_t'(data_sram_en));
            end
        end else begin
            if (inst_sram_en && !first_req_seen) begin
                first_req_seen = 1'b1;
                compare_field("inst_sram_addr", `CPU_RESET_PC, inst_sram_addr);
            end
            if (inst_sram_en && inst_sram_addr == final_pc) begin
                loop_reached = 1'b1;
            end
            if (data_sram_en) begin
                assert (load_next < load_q.size()) else begin
                    $display("data read at %h with no load left in the program", data_sram_addr);
                    other_errors = other_errors + 1;
                end
                if (load_next < load_q.size()) begin
                    compare_field("data_sram_addr", load_q[load_next], data_sram_addr);
                    load_next = load_next + 1;
                end
            end
            if (debug_wb_rf_we != 4'h0) begin
                assert (exp_next < exp_q.size()) else begin
                    $display("register write at pc %h after the program had ended", debug_wb_pc);
                    other_errors = other_errors + 1;
                end
                if (exp_next < exp_q.size()) begin
                    rec      = exp_q[exp_next];
                    exp_next = exp_next + 1;
                    checked  = checked + 1;
                    compare_field("debug_wb_pc", rec.pc, debug_wb_pc);
                    compare_field("debug_wb_rf_wnum", word_t'(rec.rd), word_t'(debug_wb_rf_wnum));
                    compare_field("debug_wb_rf_wdata", rec.data, debug_wb_rf_wdata);
                end
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        generate_program();
        run_reference();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        while (!(exp_next == exp_q.size() && loop_reached)) begin
            @(posedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        report_counts();
        if (value_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end
endmodule

// File: test/cpu_assertions.sv
`timescale 1ns/1ps

module cpu_assertions import cpu_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       inst_sram_en,
    input word_t      inst_sram_addr,
    input word_t      debug_wb_pc,
    input logic [3:0] debug_wb_rf_we,
    input reg_addr_t  debug_wb_rf_wnum,
    input word_t      debug_wb_rf_wdata
);
    inst_addr_aligned: assert property (
        @(posedge clk) disable iff (reset)
        inst_sram_en |-> inst_sram_addr[1:0] == 2'b00
    ) else $error("instruction fetch address %h not word aligned", inst_sram_addr);

    // byte enables are one write enable copied four times
    trace_we_replicated: assert property (
        @(posedge clk) disable iff (reset)
        debug_wb_rf_we == 4'h0 || debug_wb_rf_we == 4'hf
    ) else $error("trace write enable %b is partial", debug_wb_rf_we);

    trace_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(debug_wb_rf_we)
        && (debug_wb_rf_we == 4'h0
            || !$isunknown({debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata}))
    ) else $error("trace outputs unknown while writing");
endmodule

bind cpu_top cpu_assertions cpu_assertions_inst (
    .clk               (clk),
    .reset             (reset),
    .inst_sram_en      (inst_sram_en),
    .inst_sram_addr    (inst_sram_addr),
    .debug_wb_pc       (debug_wb_pc),
    .debug_wb_rf_we    (debug_wb_rf_we),
    .debug_wb_rf_wnum  (debug_wb_rf_wnum),
    .debug_wb_rf_wdata (debug_wb_rf_wdata)
);

// File: src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output logic       inst_sram_en,
    output word_t      inst_sram_addr,
    input  word_t      inst_sram_rdata,
    output logic       data_sram_en,
    output word_t      data_sram_addr,
    input  word_t      data_sram_rdata,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_addr_t  debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);
    logic               fs_valid;
    word_t              fs_pc;
    logic               ds_allowin;
    logic               br_taken;
    word_t              br_target;
    reg_addr_t          rf_raddr1;
    reg_addr_t          rf_raddr2;
    word_t              rf_rdata1;
    word_t              rf_rdata2;
    logic               ds_valid;
    decode_to_execute_t ds_data;
    logic               es_allowin;
    logic               es_valid;
    execute_to_memory_t es_data;
    ex_bypass_t         ex_bypass;
    rf_write_t          mem_wr;  // register write, bypass and trace

    fetch_stage fetch_inst (
        .clk            (clk),
        .reset          (reset),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .next_allowin   (ds_allowin),
        .inst_sram_en   (inst_sram_en),
        .inst_sram_addr (inst_sram_addr),
        .out_valid      (fs_valid),
        .out_data       (fs_pc)
    );

    decode_stage decode_inst (
        .clk             (clk),
        .reset           (reset),
        .in_valid        (fs_valid),
        .in_pc           (fs_pc),
        .inst_sram_rdata (inst_sram_rdata),
        .allowin         (ds_allowin),
        .rf_raddr1       (rf_raddr1),
        .rf_raddr2       (rf_raddr2),
        .rf_rdata1       (rf_rdata1),
        .rf_rdata2       (rf_rdata2),
        .ex_bypass       (ex_bypass),
        .mem_bypass      (mem_wr),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .out_valid       (ds_valid),
        .out_data        (ds_data),
        .next_allowin    (es_allowin)
    );

    regfile regfile_inst (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (mem_wr)
    );

    execute_stage execute_inst (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (ds_valid),
        .in_data        (ds_data),
        .allowin        (es_allowin),
        .data_sram_en   (data_sram_en),
        .data_sram_addr (data_sram_addr),
        .bypass         (ex_bypass),
        .out_valid      (es_valid),
        .out_data       (es_data)
    );

    memory_stage memory_inst (
        .clk             (clk),
        .reset           (reset),
        .in_valid        (es_valid),
        .in_data         (es_data),
        .data_sram_rdata (data_sram_rdata),
        .allowin         (),  // always open, execute assumes it
        .wr              (mem_wr),
        .debug_wb_pc     (debug_wb_pc)
    );

    assign debug_wb_rf_we    = {4{mem_wr.we}};
    assign debug_wb_rf_wnum  = mem_wr.addr;
    assign debug_wb_rf_wdata = mem_wr.data;
endmodule

// File: src/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  execute_to_memory_t in_data,
    input  word_t              data_sram_rdata,
    output logic               allowin,
    output rf_write_t          wr,
    output word_t              debug_wb_pc
);
    execute_to_memory_t em;
    logic               valid;

    stage_reg #(
        .payload_t (execute_to_memory_t)
    ) ms_reg (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .allowin      (allowin),
        .out_valid    (valid),
        .out_data     (em),
        .next_allowin (1'b1)  // last stage, retires every cycle
    );

    // single point where the write enable meets valid
    assign wr.we   = valid && em.rf_we;
    assign wr.addr = em.dest;
    assign wr.data = em.is_load ? data_sram_rdata : em.alu_result;

    assign debug_wb_pc = em.pc;
endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  decode_to_execute_t in_data,
    output logic               allowin,
    output logic               data_sram_en,
    output word_t              data_sram_addr,
    output ex_bypass_t         bypass,
    output logic               out_valid,
    output execute_to_memory_t out_data
);
    decode_to_execute_t de;
    logic               valid;
    word_t              alu_result;

    stage_reg #(
        .payload_t (decode_to_execute_t)
    ) es_reg (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .allowin      (allowin),
        .out_valid    (valid),
        .out_data     (de),
        .next_allowin (1'b1)  // memory stage never stalls
    );

    always_comb begin
        case (de.alu_op)
            ALU_ADD:  alu_result = de.src1 + de.src2;
            ALU_SUB:  alu_result = de.src1 - de.src2;
            ALU_SLT:  alu_result = word_t'($signed(de.src1) < $signed(de.src2));
            ALU_SLTU: alu_result = word_t'(de.src1 < de.src2);
            ALU_AND:  alu_result = de.src1 & de.src2;
            ALU_NOR:  alu_result = ~(de.src1 | de.src2);
            ALU_OR:   alu_result = de.src1 | de.src2;
            ALU_XOR:  alu_result = de.src1 ^ de.src2;
            ALU_SLL:  alu_result = de.src1 << de.src2[4:0];
            ALU_SRL:  alu_result = de.src1 >> de.src2[4:0];
            ALU_SRA:  alu_result = $signed(de.src1) >>> de.src2[4:0];
            ALU_LUI:  alu_result = de.src2;  // immediate already shifted
            default:  alu_result = '0;
        endcase
    end

    assign data_sram_en   = valid && de.is_load;
    assign data_sram_addr = alu_result;

    assign bypass.wr.we        = valid && de.rf_we;
    assign bypass.wr.addr      = de.dest;
    assign bypass.wr.data      = alu_result;  // meaningless while a load is pending
    assign bypass.load_pending = valid && de.is_load;

    assign out_valid = valid;
    assign out_data  = '{
        pc:         de.pc,
        alu_result: alu_result,
        dest:       de.dest,
        rf_we:      de.rf_we,
        is_load:    de.is_load
    };
endmodule

// File: src/regfile.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module regfile import cpu_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  rf_write_t wr
);
    word_t regs [1:(1 << `CPU_REG_ADDR_W) - 1];  // no storage for r0

    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  word_t              in_pc,
    input  word_t              inst_sram_rdata,
    output logic               allowin,
    output reg_addr_t          rf_raddr1,
    output reg_addr_t          rf_raddr2,
    input  word_t              rf_rdata1,
    input  word_t              rf_rdata2,
    input  ex_bypass_t         ex_bypass,
    input  rf_write_t          mem_bypass,
    output logic               br_taken,
    output word_t              br_target,
    output logic               out_valid,
    output decode_to_execute_t out_data,
    input  logic               next_allowin
);
    fetch_to_decode_t fd_in;
    fetch_to_decode_t fd;
    logic             valid;
    logic             ready_go;
    logic             load_use;
    word_t            inst;
    logic [16:0]      op17;
    logic             inst_add_w;
    logic             inst_sub_w;
    logic             inst_slt;
    logic             inst_sltu;
    logic             inst_nor;
    logic             inst_and;
    logic             inst_or;
    logic             inst_xor;
    logic             inst_slli_w;
    logic             inst_srli_w;
    logic             inst_srai_w;
    logic             inst_addi_w;
    logic             inst_ld_w;
    logic             inst_lu12i_w;
    logic             inst_b;
    logic             inst_beq;
    logic             inst_bne;
    logic             alu_rr;
    logic             shift_imm;
    logic             src2_is_imm;
    logic             gr_we;
    word_t            imm;
    word_t            br_offs;
    word_t            rj_value;
    word_t            rkd_value;
    alu_op_e          alu_op;

    // youngest producer wins: execute, then memory, then register file
    function automatic word_t fwd_value(
        input reg_addr_t  addr,
        input word_t      rf_data,
        input ex_bypass_t ex,
        input rf_write_t  mem
    );
        if (addr == '0) begin
            return '0;
        end else if (ex.wr.we && ex.wr.addr == addr) begin
            return ex.wr.data;
        end else if (mem.we && mem.addr == addr) begin
            return mem.data;
        end
        return rf_data;
    endfunction

    assign fd_in = '{pc: in_pc, inst: inst_sram_rdata};  // inst arrives with the latch

    stage_reg #(
        .payload_t (fetch_to_decode_t)
    ) ds_reg (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid && !br_taken),  // cancel the slot behind a taken branch
        .in_data      (fd_in),
        .allowin      (allowin),
        .out_valid    (valid),
        .out_data     (fd),
        .next_allowin (next_allowin && ready_go)
    );

    assign inst = fd.inst;
    assign op17 = inst[31:15];

    assign inst_add_w   = op17 == 17'h00020;
    assign inst_sub_w   = op17 == 17'h00022;
    assign inst_slt     = op17 == 17'h00024;
    assign inst_sltu    = op17 == 17'h00025;
    assign inst_nor     = op17 == 17'h00028;
    assign inst_and     = op17 == 17'h00029;
    assign inst_or      = op17 == 17'h0002a;
    assign inst_xor     = op17 == 17'h0002b;
    assign inst_slli_w  = op17 == 17'h00081;
    assign inst_srli_w  = op17 == 17'h00089;
    assign inst_srai_w  = op17 == 17'h00091;
    assign inst_addi_w  = inst[31:22] == 10'h00a;
    assign inst_ld_w    = inst[31:22] == 10'h0a2;
    assign inst_lu12i_w = inst[31:25] == 7'b0001010;
    assign inst_b       = inst[31:26] == 6'h14;
    assign inst_beq     = inst[31:26] == 6'h16;
    assign inst_bne     = inst[31:26] == 6'h17;

    assign alu_rr = inst_add_w | inst_sub_w | inst_slt | inst_sltu
                  | inst_nor | inst_and | inst_or | inst_xor;
    assign shift_imm   = inst_slli_w | inst_srli_w | inst_srai_w;
    assign src2_is_imm = shift_imm | inst_addi_w | inst_ld_w | inst_lu12i_w;
    assign gr_we       = alu_rr | src2_is_imm;  // every imm form writes rd

    always_comb begin
        case (1'b1)
            inst_sub_w:   alu_op = ALU_SUB;
            inst_slt:     alu_op = ALU_SLT;
            inst_sltu:    alu_op = ALU_SLTU;
            inst_and:     alu_op = ALU_AND;
            inst_nor:     alu_op = ALU_NOR;
            inst_or:      alu_op = ALU_OR;
            inst_xor:     alu_op = ALU_XOR;
            inst_slli_w:  alu_op = ALU_SLL;
            inst_srli_w:  alu_op = ALU_SRL;
            inst_srai_w:  alu_op = ALU_SRA;
            inst_lu12i_w: alu_op = ALU_LUI;
            default:      alu_op = ALU_ADD;  // add, addi, ld address
        endcase
    end

    assign imm = inst_lu12i_w ? {inst[24:5], 12'b0} : {{20{inst[21]}}, inst[21:10]};
    assign br_offs = inst_b ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00}
                            : {{14{inst[25]}}, inst[25:10], 2'b00};

    // unused ports read r0 so they never match a hazard
    assign rf_raddr1 = (alu_rr | shift_imm | inst_addi_w | inst_ld_w | inst_beq | inst_bne)
                       ? inst[9:5] : '0;
    assign rf_raddr2 = alu_rr ? inst[14:10] : (inst_beq | inst_bne) ? inst[4:0] : '0;

    assign rj_value  = fwd_value(rf_raddr1, rf_rdata1, ex_bypass, mem_bypass);
    assign rkd_value = fwd_value(rf_raddr2, rf_rdata2, ex_bypass, mem_bypass);

    assign load_use = valid && ex_bypass.load_pending
                      && ((rf_raddr1 != '0 && rf_raddr1 == ex_bypass.wr.addr)
                       || (rf_raddr2 != '0 && rf_raddr2 == ex_bypass.wr.addr));
    assign ready_go  = !load_use;
    assign out_valid = valid && ready_go;

    assign br_taken  = valid && ready_go
                       && (inst_b
                        || (inst_beq && rj_value == rkd_value)
                        || (inst_bne && rj_value != rkd_value));
    assign br_target = fd.pc + br_offs;

    assign out_data = '{
        pc:      fd.pc,
        alu_op:  alu_op,
        src1:    rj_value,
        src2:    src2_is_imm ? imm : rkd_value,
        dest:    inst[4:0],
        rf_we:   gr_we,
        is_load: inst_ld_w
    };
endmodule

// File: src/fetch_stage.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  br_taken,
    input  word_t br_target,
    input  logic  next_allowin,
    output logic  inst_sram_en,
    output word_t inst_sram_addr,
    output logic  out_valid,
    output word_t out_data
);
    word_t pc;
    word_t next_pc;
    logic  allowin;

    assign next_pc        = br_taken ? br_target : pc + `CPU_INST_BYTES;
    assign inst_sram_en   = allowin;
    assign inst_sram_addr = next_pc;

    // one step below reset pc so the first request is the reset address
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CPU_RESET_PC - `CPU_INST_BYTES;
        end else if (allowin) begin
            pc <= next_pc;
        end
    end

    stage_reg #(
        .payload_t (word_t)
    ) fs_reg (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (1'b1),         // a request goes out every accepted cycle
        .in_data      (next_pc),
        .allowin      (allowin),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .next_allowin (next_allowin)
    );
endmodule

// File: src/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     allowin,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     next_allowin
);
    logic valid;

    assign allowin   = !valid || next_allowin;  // empty, or item leaves now
    assign out_valid = valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            out_data <= in_data;  // hold while stalled
        end
    end
endmodule

// File: src/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]       word_t;
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_to_decode_t;

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        word_t     src1;        // forwarded rj
        word_t     src2;        // forwarded rk/rd or immediate
        reg_addr_t dest;
        logic      rf_we;
        logic      is_load;
    } decode_to_execute_t;

    typedef struct packed {
        word_t     pc;
        word_t     alu_result;  // load address for ld.w
        reg_addr_t dest;
        logic      rf_we;
        logic      is_load;
    } execute_to_memory_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    typedef struct packed {
        rf_write_t wr;
        logic      load_pending;  // data not ready until memory stage
    } ex_bypass_t;

endpackage

// File: src/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path and address width
`define CPU_XLEN 32

// register index width, 32 architectural registers
`define CPU_REG_ADDR_W 5

// first address fetched out of reset
`define CPU_RESET_PC 32'h1c00_0000

// sequential pc step
`define CPU_INST_BYTES 4

`endif
